// ==== design/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data path and program counter width
`define EX_XLEN 64

// instruction word width
`define EX_ILEN 32

// destination register index
`define EX_REG_IDX_W 5

// branch offset bits 12..1
`define EX_BIMM_W 12

// opcode field of the conditional branches
`define EX_OPCODE_BRANCH 7'b1100011

`endif

// ==== design/ex_pkg.sv ====
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

	typedef logic [`EX_XLEN-1:0]      data_t;
	typedef logic [`EX_XLEN-1:0]      addr_t;
	typedef logic [`EX_ILEN-1:0]      ins_t;
	typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`EX_BIMM_W-1:0]    b_imm_t; // offset without bit 0

	// numbering follows the decode stage
	typedef enum logic [4:0] {
		op_add    = 5'd0,
		op_addw   = 5'd1,
		op_sll    = 5'd2,
		op_sllw   = 5'd3,
		op_sra    = 5'd4,
		op_sraw   = 5'd5,
		op_srl    = 5'd6,
		op_srlw   = 5'd7,
		op_and    = 5'd8,
		op_or     = 5'd9,
		op_xor    = 5'd10,
		op_slt    = 5'd11,
		op_sltu   = 5'd12,
		op_eq     = 5'd13,
		op_ne     = 5'd14,
		op_sge    = 5'd15,
		op_sgeu   = 5'd16,
		op_sub    = 5'd17,
		op_subw   = 5'd18,
		op_mul    = 5'd19,
		op_mulh   = 5'd20,
		op_mulhu  = 5'd21,
		op_mulw   = 5'd22,
		op_div    = 5'd23,
		op_divu   = 5'd24,
		op_divw   = 5'd25,
		op_divuw  = 5'd26,
		op_rem    = 5'd27,
		op_remu   = 5'd28,
		op_remuw  = 5'd29,
		op_remw   = 5'd30
	} alu_op_e;

endpackage

`default_nettype wire

// ==== design/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  ex_pkg::alu_op_e op,
	input  ex_pkg::data_t   src_a,
	input  ex_pkg::data_t   src_b,
	input  ex_pkg::addr_t   pc,
	input  ex_pkg::b_imm_t  b_imm,
	input  logic            is_branch,
	output ex_pkg::data_t   alu_result,
	output logic            branch_taken,
	output ex_pkg::addr_t   branch_target
);
	import ex_pkg::*;

	logic [31:0] word_res;
	logic        is_word;
	addr_t       b_offset;

	always_comb begin
		word_res   = '0;
		is_word    = 1'b0;
		alu_result = '0; // long and unknown ops
		case (op)
			op_add:  alu_result = src_a + src_b;
			op_sll:  alu_result = src_a << src_b[5:0];
			op_sra:  alu_result = $signed(src_a) >>> src_b[5:0];
			op_srl:  alu_result = src_a >> src_b[5:0];
			op_and:  alu_result = src_a & src_b;
			op_or:   alu_result = src_a | src_b;
			op_xor:  alu_result = src_a ^ src_b;
			op_slt:  alu_result = data_t'($signed(src_a) < $signed(src_b));
			op_sltu: alu_result = data_t'(src_a < src_b);
			op_eq:   alu_result = data_t'(src_a == src_b);
			op_ne:   alu_result = data_t'(src_a != src_b);
			op_sge:  alu_result = data_t'($signed(src_a) >= $signed(src_b));
			op_sgeu: alu_result = data_t'(src_a >= src_b);
			op_sub:  alu_result = src_a - src_b;
			op_addw: begin
				is_word  = 1'b1;
				word_res = src_a[31:0] + src_b[31:0];
			end
			op_sllw: begin
				is_word  = 1'b1;
				word_res = src_a[31:0] << src_b[4:0];
			end
			op_sraw: begin
				is_word  = 1'b1;
				word_res = $signed(src_a[31:0]) >>> src_b[4:0];
			end
			op_srlw: begin
				is_word  = 1'b1;
				word_res = src_a[31:0] >> src_b[4:0];
			end
			op_subw: begin
				is_word  = 1'b1;
				word_res = src_a[31:0] - src_b[31:0];
			end
			default: alu_result = '0;
		endcase
		if (is_word) begin
			alu_result = {{32{word_res[31]}}, word_res}; // sign-extend word forms
		end
	end

	// offset is bits 12..1, so append a zero and sign-extend
	assign b_offset = {{($bits(addr_t) - $bits(b_imm_t) - 1){b_imm[$bits(b_imm_t) - 1]}},
		b_imm, 1'b0};

	assign branch_target = pc + b_offset;
	assign branch_taken  = is_branch & (alu_result != '0);

endmodule

`default_nettype wire

// ==== design/ex_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_multiplier (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  logic          word,
	input  logic          signed_ops,
	input  ex_pkg::data_t mul_a,
	input  ex_pkg::data_t mul_b,
	input  logic          ack,
	output logic          busy,
	output logic          done,
	output ex_pkg::data_t prod_hi,
	output ex_pkg::data_t prod_lo
);
	import ex_pkg::*;

	data_t        op_a;
	data_t        op_b;
	logic         neg_a;
	logic         neg_b;
	data_t        mag_a;
	data_t        mag_b;
	data_t        mcand;
	logic [127:0] acc; // upper half sums, lower half holds the multiplier
	logic         neg;
	logic [5:0]   step;
	logic [64:0]  sum;
	logic [127:0] prod;

	assign op_a  = word ? {{32{mul_a[31]}}, mul_a[31:0]} : mul_a;
	assign op_b  = word ? {{32{mul_b[31]}}, mul_b[31:0]} : mul_b;
	assign neg_a = signed_ops & op_a[63];
	assign neg_b = signed_ops & op_b[63];
	assign mag_a = neg_a ? -op_a : op_a;
	assign mag_b = neg_b ? -op_b : op_b;

	assign sum  = {1'b0, acc[127:64]} + (acc[0] ? {1'b0, mcand} : 65'd0);
	assign prod = neg ? -acc : acc;

	assign prod_hi = prod[127:64];
	assign prod_lo = prod[63:0];

	// one step per cycle after the start edge, done with the 64th
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 6'd1;
			if (step == 6'd63) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end else if (ack) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= mag_a;
			acc   <= {64'd0, mag_b};
			neg   <= neg_a ^ neg_b;
		end else if (busy) begin
			acc <= {sum, acc[63:1]}; // add then shift right
		end
	end

endmodule

`default_nettype wire

// ==== design/ex_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_divider (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  logic          word,
	input  logic          signed_ops,
	input  ex_pkg::data_t dividend,
	input  ex_pkg::data_t divisor,
	input  logic          ack,
	output logic          busy,
	output logic          done,
	output ex_pkg::data_t quotient,
	output ex_pkg::data_t remainder
);
	import ex_pkg::*;

	data_t       op_a;
	data_t       op_b;
	logic        neg_a;
	logic        neg_b;
	data_t       mag_a;
	data_t       mag_b;
	data_t       dsor;
	data_t       quo_r; // dividend bits shift out, quotient bits shift in
	data_t       rem_r;
	logic        q_neg;
	logic        r_neg;
	logic        word_r;
	logic [6:0]  step;
	logic [64:0] shifted;
	logic [64:0] diff;
	data_t       q_fix;
	data_t       r_fix;

	always_comb begin
		if (!word) begin
			op_a = dividend;
			op_b = divisor;
		end else if (signed_ops) begin
			op_a = {{32{dividend[31]}}, dividend[31:0]};
			op_b = {{32{divisor[31]}}, divisor[31:0]};
		end else begin
			op_a = {32'd0, dividend[31:0]};
			op_b = {32'd0, divisor[31:0]};
		end
	end

	assign neg_a = signed_ops & op_a[63];
	assign neg_b = signed_ops & op_b[63];
	assign mag_a = neg_a ? -op_a : op_a;
	assign mag_b = neg_b ? -op_b : op_b;

	assign shifted = {rem_r, quo_r[63]};
	assign diff    = shifted - {1'b0, dsor};
	assign q_fix   = q_neg ? -quo_r : quo_r;
	assign r_fix   = r_neg ? -rem_r : rem_r;

	assign quotient  = quo_r;
	assign remainder = rem_r;

	// 64 restoring steps, then one cycle for signs and word extension
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 7'd1;
			if (step == 7'd64) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end else if (ack) begin
			done <= 1'b0;
		end
	end

	// a zero divisor leaves all ones in the quotient and the dividend as remainder;
	// min by -1 gives 2^63 or 2^31, already the dividend once extended
	always_ff @(posedge clk) begin
		if (start) begin
			dsor   <= mag_b;
			quo_r  <= mag_a;
			rem_r  <= '0;
			q_neg  <= (neg_a ^ neg_b) & (op_b != '0); // keep all ones on /0
			r_neg  <= neg_a;
			word_r <= word;
		end else if (busy) begin
			if (step != 7'd64) begin
				if (shifted >= {1'b0, dsor}) begin
					rem_r <= diff[63:0];
					quo_r <= {quo_r[62:0], 1'b1};
				end else begin
					rem_r <= shifted[63:0];
					quo_r <= {quo_r[62:0], 1'b0};
				end
			end else begin
				quo_r <= word_r ? {{32{q_fix[31]}}, q_fix[31:0]} : q_fix;
				rem_r <= word_r ? {{32{r_fix[31]}}, r_fix[31:0]} : r_fix;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/ex_long_op_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_long_op_ctrl (
	input  logic            clk,
	input  logic            reset,
	input  logic            valid_in,
	input  ex_pkg::alu_op_e op,
	input  ex_pkg::data_t   alu_result,
	input  logic            can_accept,
	input  logic            mul_busy,
	input  logic            mul_done,
	input  ex_pkg::data_t   prod_hi,
	input  ex_pkg::data_t   prod_lo,
	input  logic            div_busy,
	input  logic            div_done,
	input  ex_pkg::data_t   quotient,
	input  ex_pkg::data_t   remainder,
	output logic            ready_in,
	output logic            mul_start,
	output logic            mul_word,
	output logic            mul_signed,
	output logic            mul_ack,
	output logic            div_start,
	output logic            div_word,
	output logic            div_signed,
	output logic            div_ack,
	output ex_pkg::data_t   ex_result
);
	import ex_pkg::*;

	logic is_mul;
	logic is_div;
	logic in_hs;
	logic waiting; // a long op with a start already issued

	assign is_mul = op inside {op_mul, op_mulh, op_mulhu, op_mulw};
	assign is_div = op inside {op_div, op_divu, op_divw, op_divuw,
		op_rem, op_remu, op_remuw, op_remw};

	assign mul_word   = (op == op_mulw);
	assign mul_signed = (op == op_mulh) | (op == op_mulw); // low half of mul is sign-blind
	assign div_word   = op inside {op_divw, op_divuw, op_remuw, op_remw};
	assign div_signed = op inside {op_div, op_divw, op_rem, op_remw};

	assign mul_start = valid_in & is_mul & ~mul_busy & ~mul_done & ~waiting;
	assign div_start = valid_in & is_div & ~div_busy & ~div_done & ~waiting;

	// held until the unit finishes and the register can take the entry
	assign ready_in = can_accept & (is_mul ? mul_done : (is_div ? div_done : 1'b1));
	assign in_hs    = valid_in & ready_in;
	assign mul_ack  = in_hs & is_mul;
	assign div_ack  = in_hs & is_div;

	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
		end else if (in_hs) begin
			waiting <= 1'b0;
		end else if (mul_start | div_start) begin
			waiting <= 1'b1;
		end
	end

	always_comb begin
		case (op)
			op_mul:   ex_result = prod_lo;
			op_mulw:  ex_result = {{32{prod_lo[31]}}, prod_lo[31:0]};
			op_mulh, op_mulhu: ex_result = prod_hi;
			op_div, op_divu, op_divw, op_divuw: ex_result = quotient;
			op_rem, op_remu, op_remuw, op_remw: ex_result = remainder;
			default:  ex_result = alu_result;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  logic             ready_in,
	input  logic             ready_out,
	input  ex_pkg::addr_t    pc,
	input  ex_pkg::ins_t     ins,
	input  ex_pkg::data_t    ex_result,
	input  ex_pkg::data_t    rt_data,
	input  ex_pkg::reg_idx_t rdest,
	input  logic             mem_w_en,
	input  logic             wb_sel,
	input  logic             reg_w_en,
	input  logic             branch_taken,
	input  ex_pkg::addr_t    branch_target,
	output logic             can_accept,
	output logic             valid_out,
	output ex_pkg::addr_t    pc_out,
	output ex_pkg::ins_t     ins_out,
	output ex_pkg::data_t    result_out,
	output ex_pkg::data_t    rt_data_out,
	output ex_pkg::reg_idx_t rdest_out,
	output logic             mem_w_en_out,
	output logic             wb_sel_out,
	output logic             reg_w_en_out,
	output logic             branch_taken_out,
	output ex_pkg::addr_t    branch_target_out
);
	import ex_pkg::*;

	logic load;

	assign can_accept = ~valid_out | ready_out; // empty or draining
	assign load       = valid_in & ready_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load) begin
			valid_out <= 1'b1;
		end else if (ready_out) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pc_out            <= pc;
			ins_out           <= ins;
			result_out        <= ex_result;
			rt_data_out       <= rt_data;
			rdest_out         <= rdest;
			mem_w_en_out      <= mem_w_en;
			wb_sel_out        <= wb_sel; // 1 selects memory data
			reg_w_en_out      <= reg_w_en;
			branch_taken_out  <= branch_taken;
			branch_target_out <= branch_target;
		end
	end

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	output logic             ready_in,
	input  ex_pkg::addr_t    pc,
	input  ex_pkg::ins_t     ins,
	input  ex_pkg::alu_op_e  op,
	input  ex_pkg::data_t    src_a,
	input  ex_pkg::data_t    src_b,
	input  ex_pkg::data_t    rt_data,
	input  ex_pkg::b_imm_t   b_imm,
	input  logic             is_branch,
	input  logic             mem_w_en,
	input  logic             wb_sel,
	input  logic             reg_w_en,
	input  ex_pkg::reg_idx_t rdest,
	input  logic             ready_out,
	output logic             valid_out,
	output ex_pkg::addr_t    pc_out,
	output ex_pkg::ins_t     ins_out,
	output ex_pkg::data_t    result_out,
	output ex_pkg::data_t    rt_data_out,
	output ex_pkg::reg_idx_t rdest_out,
	output logic             mem_w_en_out,
	output logic             wb_sel_out,
	output logic             reg_w_en_out,
	output logic             branch_taken_out,
	output ex_pkg::addr_t    branch_target_out
);
	import ex_pkg::*;

	data_t alu_result;
	data_t ex_result;
	logic  branch_taken;
	addr_t branch_target;
	logic  can_accept;
	logic  mul_start;
	logic  mul_word;
	logic  mul_signed;
	logic  mul_ack;
	logic  mul_busy;
	logic  mul_done;
	data_t prod_hi;
	data_t prod_lo;
	logic  div_start;
	logic  div_word;
	logic  div_signed;
	logic  div_ack;
	logic  div_busy;
	logic  div_done;
	data_t quotient;
	data_t remainder;

	ex_alu ex_alu_i (.*);

	ex_multiplier ex_multiplier_i (
		.clk(clk), .reset(reset),
		.start(mul_start), .word(mul_word), .signed_ops(mul_signed),
		.mul_a(src_a), .mul_b(src_b), .ack(mul_ack),
		.busy(mul_busy), .done(mul_done),
		.prod_hi(prod_hi), .prod_lo(prod_lo)
	);

	ex_divider ex_divider_i (
		.clk(clk), .reset(reset),
		.start(div_start), .word(div_word), .signed_ops(div_signed),
		.dividend(src_a), .divisor(src_b), .ack(div_ack),
		.busy(div_busy), .done(div_done),
		.quotient(quotient), .remainder(remainder)
	);

	ex_long_op_ctrl ex_long_op_ctrl_i (.*);

	ex_mem_reg ex_mem_reg_i (.*);

endmodule

`default_nettype wire

// ==== testbench/ex_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage_tb;
	import ex_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int N_ALU = 200;
	localparam int N_BR = 40;
	localparam int N_MUL = 48;
	localparam int N_DIV = 64;
	localparam int N_CORNER = 32; // four per divide op
	localparam int N_MIX = 120;
	localparam int N_OPS = N_ALU + N_BR + N_MUL + N_DIV + N_CORNER + N_MIX;
	localparam int LIMIT_CYCLES = N_OPS * 70 + 200;
	localparam int SNAP_W = 4 * `EX_XLEN + `EX_ILEN + `EX_REG_IDX_W + 4;

	typedef struct packed {
		alu_op_e  op;
		addr_t    pc;
		ins_t     ins;
		data_t    result;
		data_t    rt_data;
		reg_idx_t rdest;
		logic     mem_w_en;
		logic     wb_sel;
		logic     reg_w_en;
		logic     taken;
		addr_t    target;
	} entry_t;

	logic     clk = 1'b0;
	logic     reset;
	logic     valid_in;
	logic     ready_in;
	addr_t    pc;
	ins_t     ins;
	alu_op_e  op;
	data_t    src_a;
	data_t    src_b;
	data_t    rt_data;
	b_imm_t   b_imm;
	logic     is_branch;
	logic     mem_w_en;
	logic     wb_sel;
	logic     reg_w_en;
	reg_idx_t rdest;
	logic     ready_out;
	logic     valid_out;
	addr_t    pc_out;
	ins_t     ins_out;
	data_t    result_out;
	data_t    rt_data_out;
	reg_idx_t rdest_out;
	logic     mem_w_en_out;
	logic     wb_sel_out;
	logic     reg_w_en_out;
	logic     branch_taken_out;
	addr_t    branch_target_out;

	logic [31:0]       stim_lfsr = 32'h8a66;
	logic [31:0]       bp_lfsr = 32'h8a66;
	entry_t            expected_q[$];
	int                sent = 0;
	int                received = 0;
	int                value_errors = 0;
	int                protocol_errors = 0;
	logic              held;
	logic [SNAP_W-1:0] snap;

	ex_stage ex_stage_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic data_t rand_bits(input int n);
		data_t v;
		int    i;
		v = '0;
		for (i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[62:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	function automatic alu_op_e pick_op(input int lo, input int hi);
		int r;
		r = int'(rand_bits(8));
		return alu_op_e'(5'(lo + r % (hi - lo + 1)));
	endfunction

	function automatic data_t pick_operand();
		logic [2:0] sel;
		sel = 3'(rand_bits(3));
		case (sel)
			3'd0: return '0;
			3'd1: return '1;
			3'd2: return {1'b1, 63'd0};
			3'd3: return {{33{1'b1}}, 31'd0}; // most negative word
			3'd4: return 64'd1;
			default: return rand_bits(64);
		endcase
	endfunction

	function automatic data_t sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	// zero divisor and signed overflow first, then magnitudes with fixed signs
	function automatic data_t div_ref(input data_t a, input data_t b, input logic sgn,
		input logic want_rem);
		data_t ma;
		data_t mb;
		data_t q;
		data_t r;
		logic  na;
		logic  nb;
		if (b == '0) begin
			return want_rem ? a : '1;
		end
		if (sgn && a == {1'b1, 63'd0} && b == '1) begin
			return want_rem ? '0 : a;
		end
		na = sgn & a[63];
		nb = sgn & b[63];
		ma = na ? -a : a;
		mb = nb ? -b : b;
		q  = ma / mb;
		r  = ma % mb;
		if (na ^ nb) q = -q;
		if (na) r = -r;
		return want_rem ? r : q;
	endfunction

	function automatic data_t ref_result(input alu_op_e o, input data_t a, input data_t b);
		logic [127:0] p;
		data_t        t;
		data_t        r;
		r = '0;
		case (o)
			op_add:   r = a + b;
			op_addw:  r = sext32(a[31:0] + b[31:0]);
			op_sll:   r = a << b[5:0];
			op_sllw:  r = sext32(a[31:0] << b[4:0]);
			op_sra:   r = $signed(a) >>> b[5:0];
			op_sraw: begin
				t = sext32(a[31:0]);
				r = $signed(t) >>> b[4:0]; // upper bits stay copies of bit 31
			end
			op_srl:   r = a >> b[5:0];
			op_srlw:  r = sext32(a[31:0] >> b[4:0]);
			op_and:   r = a & b;
			op_or:    r = a | b;
			op_xor:   r = a ^ b;
			op_slt:   r = {63'd0, $signed(a) < $signed(b)};
			op_sltu:  r = {63'd0, a < b};
			op_eq:    r = {63'd0, a == b};
			op_ne:    r = {63'd0, a != b};
			op_sge:   r = {63'd0, !($signed(a) < $signed(b))};
			op_sgeu:  r = {63'd0, !(a < b)};
			op_sub:   r = a - b;
			op_subw:  r = sext32(a[31:0] - b[31:0]);
			op_mul:   r = a * b;
			op_mulh: begin
				p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
				r = p[127:64];
			end
			op_mulhu: begin
				p = {64'd0, a} * {64'd0, b};
				r = p[127:64];
			end
			op_mulw:  r = sext32(a[31:0] * b[31:0]);
			op_div:   r = div_ref(a, b, 1'b1, 1'b0);
			op_divu:  r = div_ref(a, b, 1'b0, 1'b0);
			op_rem:   r = div_ref(a, b, 1'b1, 1'b1);
			op_remu:  r = div_ref(a, b, 1'b0, 1'b1);
			op_divw, op_remw: begin
				t = div_ref(sext32(a[31:0]), sext32(b[31:0]), 1'b1, o == op_remw);
				r = sext32(t[31:0]);
			end
			op_divuw, op_remuw: begin
				t = div_ref({32'd0, a[31:0]}, {32'd0, b[31:0]}, 1'b0, o == op_remuw);
				r = sext32(t[31:0]);
			end
			default:  r = '0;
		endcase
		return r;
	endfunction

	// drive one entry, hold it until ready_in, then queue what should come out
	task automatic send(input alu_op_e o, input data_t a, input data_t b, input logic br);
		entry_t e;
		b_imm_t imm;
		data_t  ctl;
		e.op = o;
		e.pc = rand_bits(64) & ~64'd3;
		e.ins = ins_t'(rand_bits(32));
		if (br) e.ins[6:0] = `EX_OPCODE_BRANCH;
		e.rt_data = rand_bits(64);
		e.rdest = reg_idx_t'(rand_bits(5));
		ctl = rand_bits(3);
		e.mem_w_en = ctl[0];
		e.wb_sel = ctl[1];
		e.reg_w_en = ctl[2];
		imm = b_imm_t'(rand_bits(12));
		e.result = ref_result(o, a, b);
		e.taken = br & (e.result != '0);
		e.target = e.pc + ({{52{imm[11]}}, imm} << 1);
		valid_in  <= 1'b1;
		op        <= o;
		src_a     <= a;
		src_b     <= b;
		pc        <= e.pc;
		ins       <= e.ins;
		rt_data   <= e.rt_data;
		rdest     <= e.rdest;
		b_imm     <= imm;
		is_branch <= br;
		mem_w_en  <= e.mem_w_en;
		wb_sel    <= e.wb_sel;
		reg_w_en  <= e.reg_w_en;
		do @(posedge clk); while (!ready_in);
		expected_q.push_back(e);
		sent++;
		if (rand_bits(3) == '0) begin
			valid_in <= 1'b0; // idle gap
			@(posedge clk);
		end
	endtask

	task automatic run_group(input int count, input int lo, input int hi, input logic br);
		alu_op_e o;
		int      i;
		for (i = 0; i < count; i++) begin
			o = pick_op(lo, hi);
			send(o, pick_operand(), pick_operand(), br && (o inside {[op_slt:op_sgeu]}));
		end
	endtask

	task automatic run_div_corners();
		alu_op_e o;
		data_t   r;
		int      k;
		for (k = 23; k <= 30; k++) begin
			o = alu_op_e'(5'(k));
			r = rand_bits(64);
			send(o, r, '0, 1'b0);
			send(o, r, {r[63:32] | 32'd1, 32'd0}, 1'b0); // zero only in the low word
			send(o, {1'b1, 63'd0}, '1, 1'b0);
			send(o, {r[31:0], 32'h8000_0000}, {r[63:32], 32'hffff_ffff}, 1'b0);
		end
	endtask

	task automatic check_field(input string test, input string field, input data_t exp,
		input data_t got);
		assert (got === exp) else begin
			value_errors++;
			$display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, got);
		end
	endtask

	task automatic compare_entry(input entry_t e);
		alu_op_e o;
		string   name;
		o = e.op;
		name = $sformatf("%s #%0d", o.name(), received);
		check_field(name, "result", e.result, result_out);
		check_field(name, "pc", e.pc, pc_out);
		check_field(name, "ins", 64'(e.ins), 64'(ins_out));
		check_field(name, "rt_data", e.rt_data, rt_data_out);
		check_field(name, "rdest", 64'(e.rdest), 64'(rdest_out));
		check_field(name, "mem/wb/reg ctl", 64'({e.mem_w_en, e.wb_sel, e.reg_w_en}),
			64'({mem_w_en_out, wb_sel_out, reg_w_en_out}));
		check_field(name, "branch_taken", 64'(e.taken), 64'(branch_taken_out));
		check_field(name, "branch_target", e.target, branch_target_out);
	endtask

	initial begin : back_pressure
		logic first;
		ready_out <= 1'b0;
		forever begin
			@(posedge clk);
			bp_lfsr = lfsr_next(bp_lfsr);
			first = bp_lfsr[0];
			bp_lfsr = lfsr_next(bp_lfsr);
			ready_out <= first | bp_lfsr[0]; // high about three cycles in four
		end
	end

	always @(posedge clk) begin : monitor
		entry_t            e;
		logic [SNAP_W-1:0] snap_now;
		if (reset) begin
			held = 1'b0;
		end else begin
			snap_now = {pc_out, ins_out, result_out, rt_data_out, rdest_out, mem_w_en_out,
				wb_sel_out, reg_w_en_out, branch_taken_out, branch_target_out};
			assert (!(valid_out && sent == 0)) else begin
				protocol_errors++;
				$display("valid_out is high although no input was accepted yet");
			end
			if (held) begin
				assert (snap_now === snap) else begin
					protocol_errors++;
					$display("outputs changed while valid_out was high and ready_out low");
				end
			end
			if (valid_out && ready_out) begin
				assert (expected_q.size() > 0) else begin
					protocol_errors++;
					$display("valid_out delivered an entry that was never sent");
				end
				if (expected_q.size() > 0) begin
					e = expected_q.pop_front();
					compare_entry(e);
					received++;
				end
			end
			held = valid_out && !ready_out;
			snap = snap_now;
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * LIMIT_CYCLES);
		$display("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("value errors: %0d, protocol errors: %0d, entries checked: %0d",
			value_errors, protocol_errors, received);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		reset     <= 1'b1;
		valid_in  <= 1'b0;
		op        <= op_add;
		pc        <= '0;
		ins       <= '0;
		src_a     <= '0;
		src_b     <= '0;
		rt_data   <= '0;
		b_imm     <= '0;
		is_branch <= 1'b0;
		mem_w_en  <= 1'b0;
		wb_sel    <= 1'b0;
		reg_w_en  <= 1'b0;
		rdest     <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);
		run_group(N_ALU, 0, 18, 1'b0);
		run_group(N_BR, 11, 16, 1'b1);
		run_group(N_MUL, 19, 22, 1'b0);
		run_group(N_DIV, 23, 30, 1'b0);
		run_div_corners();
		run_group(N_MIX, 0, 30, 1'b1);
		valid_in <= 1'b0;
		while (expected_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		assert (!valid_out) else begin
			protocol_errors++;
			$display("valid_out still high after every sent entry was delivered");
		end
		$display("value errors: %0d, protocol errors: %0d, entries checked: %0d",
			value_errors, protocol_errors, received);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_multiplier.sv
design/ex_divider.sv
design/ex_long_op_ctrl.sv
design/ex_mem_reg.sv
design/ex_stage.sv
testbench/ex_stage_tb.sv
